// ==== rtl/audio_pkg.sv ====
package audio_pkg;

	// AC-link frame geometry
	localparam int frame_bits = 256;
	localparam int tag_bits = 16;
	localparam int slot_bits = 20;
	localparam int pad_bits = frame_bits - tag_bits - 4 * slot_bits; // Slots 5 to 12
	localparam int cnt_w = $clog2(frame_bits);

	// Sample FIFO
	localparam int fifo_depth = 16;
	localparam int fifo_level_w = 5;
	localparam int fifo_ptr_w = fifo_level_w - 1;
	localparam int sample_w = 32; // Left in upper half, right in lower half

	// Register fields
	localparam int addr_w = 4;
	localparam int half_w = 16; // PCM sample, volume and underrun count width

	typedef enum logic [addr_w-1:0] {
		addr_ctrl   = 4'h0,
		addr_status = 4'h4,
		addr_sample = 4'h8,
		addr_volume = 4'hC
	} reg_addr_e;

	// Codec register indices, as carried in slot 1
	typedef enum logic [6:0] {
		codec_master_vol = 7'h02,
		codec_pcm_vol    = 7'h18
	} codec_reg_e;

	typedef enum logic [1:0] {
		conf_idle,
		conf_master,
		conf_pcm
	} conf_state_e;

	typedef enum logic {
		link_reset,
		link_run
	} link_state_e;

endpackage

// ==== rtl/ac97_slot_if.sv ====
interface ac97_slot_if;

	logic strobe; // One cycle at the last bit of a frame

	logic [audio_pkg::slot_bits-1:0] slot1;
	logic slot1_valid;
	logic [audio_pkg::slot_bits-1:0] slot2;
	logic slot2_valid;
	logic [audio_pkg::slot_bits-1:0] slot3;
	logic slot3_valid;
	logic [audio_pkg::slot_bits-1:0] slot4;
	logic slot4_valid;

	modport link (
		output strobe,
		input  slot1, slot1_valid, slot2, slot2_valid,
		input  slot3, slot3_valid, slot4, slot4_valid
	);

	modport pcm (
		input  strobe,
		output slot3, slot3_valid, slot4, slot4_valid
	);

	modport conf (
		input  strobe,
		output slot1, slot1_valid, slot2, slot2_valid
	);

endinterface

// ==== rtl/audio_apb_regs.sv ====
module audio_apb_regs (
	input  logic                                ac97_bitclk,
	input  logic                                ac97_reset_b,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [audio_pkg::addr_w-1:0]        paddr,
	input  logic [31:0]                         pwdata,
	input  logic                                full,
	input  logic [audio_pkg::fifo_level_w-1:0]  level,
	input  logic [audio_pkg::half_w-1:0]        underrun_count,
	output logic [31:0]                         prdata,
	output logic                                pready,
	output logic                                pslverr,
	output logic                                push,
	output logic [audio_pkg::sample_w-1:0]      push_data,
	output logic                                play,
	output logic                                conf_en,
	output logic [audio_pkg::half_w-1:0]        master_vol,
	output logic [audio_pkg::half_w-1:0]        pcm_vol
);

	logic access;
	logic wr;
	logic rd;
	logic mapped;
	logic is_sample;
	audio_pkg::reg_addr_e addr;

	assign access = psel & penable;
	assign wr = access & pwrite;
	assign rd = access & ~pwrite;
	assign addr = audio_pkg::reg_addr_e'(paddr);
	assign is_sample = (addr == audio_pkg::addr_sample);

	assign pready = access; // No wait states

	// Read mux and address decode
	always_comb begin
		mapped = 1'b1;
		prdata = '0;
		case (addr)
			audio_pkg::addr_ctrl: prdata[1:0] = {conf_en, play};
			audio_pkg::addr_status: begin
				prdata[audio_pkg::fifo_level_w-1:0] = level;
				prdata[8 +: audio_pkg::half_w] = underrun_count;
			end
			audio_pkg::addr_sample: prdata = '0; // Write only
			audio_pkg::addr_volume: prdata = {pcm_vol, master_vol};
			default: mapped = 1'b0;
		endcase
	end

	// Sample reads and writes into a full FIFO are rejected
	assign pslverr = (access & ~mapped) | (is_sample & (rd | (wr & full)));

	assign push = wr & is_sample & ~full;
	assign push_data = pwdata;

	always_ff @(posedge ac97_bitclk or negedge ac97_reset_b) begin
		if (!ac97_reset_b) begin
			play <= 1'b0;
			conf_en <= 1'b0;
			master_vol <= '0;
			pcm_vol <= '0;
		end else if (wr) begin
			case (addr)
				audio_pkg::addr_ctrl: begin
					play <= pwdata[0];
					conf_en <= pwdata[1];
				end
				audio_pkg::addr_volume: begin
					master_vol <= pwdata[audio_pkg::half_w-1:0];
					pcm_vol <= pwdata[31 -: audio_pkg::half_w];
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== rtl/sample_fifo.sv ====
module sample_fifo (
	input  logic                                ac97_bitclk,
	input  logic                                ac97_reset_b,
	input  logic                                push,
	input  logic [audio_pkg::sample_w-1:0]      push_data,
	input  logic                                pop,
	output logic [audio_pkg::sample_w-1:0]      pop_data,
	output logic                                empty,
	output logic                                full,
	output logic [audio_pkg::fifo_level_w-1:0]  level
);

	logic [audio_pkg::sample_w-1:0] mem [audio_pkg::fifo_depth];
	logic [audio_pkg::fifo_ptr_w-1:0] wr_ptr;
	logic [audio_pkg::fifo_ptr_w-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	assign pop_data = mem[rd_ptr]; // Head word visible without a pop
	assign empty = (level == '0);
	assign full = (level == audio_pkg::fifo_level_w'(audio_pkg::fifo_depth));

	always_ff @(posedge ac97_bitclk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	// Depth is a power of two so the pointers wrap on their own
	always_ff @(posedge ac97_bitclk or negedge ac97_reset_b) begin
		if (!ac97_reset_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level; // Both or neither
			endcase
		end
	end

endmodule

// ==== rtl/pcm_slot_packer.sv ====
module pcm_slot_packer (
	input  logic                            ac97_bitclk,
	input  logic                            ac97_reset_b,
	input  logic                            play,
	input  logic [audio_pkg::sample_w-1:0]  pop_data,
	input  logic                            empty,
	output logic                            pop,
	output logic [audio_pkg::half_w-1:0]    underrun_count,
	ac97_slot_if.pcm                        slot
);

	localparam int pad_w = audio_pkg::slot_bits - audio_pkg::half_w;

	logic underrun;

	// One FIFO word per frame, taken at the strobe
	assign pop = slot.strobe & play & ~empty;
	assign underrun = slot.strobe & play & empty;

	always_ff @(posedge ac97_bitclk or negedge ac97_reset_b) begin
		if (!ac97_reset_b) begin
			slot.slot3_valid <= 1'b0;
			slot.slot4_valid <= 1'b0;
			underrun_count <= '0;
		end else if (slot.strobe) begin
			slot.slot3_valid <= pop; // Low on underrun or when stopped
			slot.slot4_valid <= pop;
			if (underrun && underrun_count != '1)
				underrun_count <= underrun_count + 1'b1;
		end
	end

	// 16-bit samples sit in the upper bits of the 20-bit slots
	always_ff @(posedge ac97_bitclk) begin
		if (pop) begin
			slot.slot3 <= {pop_data[audio_pkg::sample_w-1 -: audio_pkg::half_w],
				{pad_w{1'b0}}};
			slot.slot4 <= {pop_data[audio_pkg::half_w-1:0], {pad_w{1'b0}}};
		end
	end

endmodule

// ==== rtl/ac97_conf.sv ====
module ac97_conf (
	input  logic                          ac97_bitclk,
	input  logic                          ac97_reset_b,
	input  logic                          conf_en,
	input  logic [audio_pkg::half_w-1:0]  master_vol,
	input  logic [audio_pkg::half_w-1:0]  pcm_vol,
	ac97_slot_if.conf                     slot
);

	localparam int pad_w = audio_pkg::slot_bits - audio_pkg::half_w;

	audio_pkg::conf_state_e state;
	audio_pkg::conf_state_e state_nxt;

	// Slot 1 write command, bit 19 low for a write
	function automatic logic [audio_pkg::slot_bits-1:0] write_cmd(
		audio_pkg::codec_reg_e idx);
		return {1'b0, idx, 12'b0};
	endfunction

	always_comb begin
		if (!conf_en)
			state_nxt = audio_pkg::conf_idle;
		else if (state == audio_pkg::conf_master)
			state_nxt = audio_pkg::conf_pcm;
		else
			state_nxt = audio_pkg::conf_master; // From idle or after PCM write
	end

	always_ff @(posedge ac97_bitclk or negedge ac97_reset_b) begin
		if (!ac97_reset_b) begin
			state <= audio_pkg::conf_idle;
			slot.slot1_valid <= 1'b0;
			slot.slot2_valid <= 1'b0;
		end else if (slot.strobe) begin
			state <= state_nxt;
			slot.slot1_valid <= (state_nxt != audio_pkg::conf_idle);
			slot.slot2_valid <= (state_nxt != audio_pkg::conf_idle);
		end
	end

	always_ff @(posedge ac97_bitclk) begin
		if (slot.strobe) begin
			if (state_nxt == audio_pkg::conf_pcm) begin
				slot.slot1 <= write_cmd(audio_pkg::codec_pcm_vol);
				slot.slot2 <= {pcm_vol, {pad_w{1'b0}}};
			end else begin
				slot.slot1 <= write_cmd(audio_pkg::codec_master_vol);
				slot.slot2 <= {master_vol, {pad_w{1'b0}}};
			end
		end
	end

endmodule

// ==== rtl/ac_link_tx.sv ====
module ac_link_tx (
	input  logic       ac97_bitclk,
	input  logic       ac97_reset_b,
	output logic       ac97_sync,
	output logic       ac97_sdata_out,
	ac97_slot_if.link  slot
);

	localparam int sb = audio_pkg::slot_bits;
	localparam int fb = audio_pkg::frame_bits;

	audio_pkg::link_state_e state;
	logic [audio_pkg::cnt_w-1:0] cnt;
	logic [audio_pkg::tag_bits-1:0] tag;
	logic [fb-1:0] frame;
	logic [fb-2:0] shreg; // Rest of the frame after its first bit
	logic any_valid;

	assign any_valid = slot.slot1_valid | slot.slot2_valid |
		slot.slot3_valid | slot.slot4_valid;

	assign tag = {any_valid, slot.slot1_valid, slot.slot2_valid,
		slot.slot3_valid, slot.slot4_valid, {(audio_pkg::tag_bits - 5){1'b0}}};

	// Invalid slots go out as zeros
	assign frame = {
		tag,
		slot.slot1 & {sb{slot.slot1_valid}},
		slot.slot2 & {sb{slot.slot2_valid}},
		slot.slot3 & {sb{slot.slot3_valid}},
		slot.slot4 & {sb{slot.slot4_valid}},
		{audio_pkg::pad_bits{1'b0}}
	};

	assign slot.strobe = (cnt == audio_pkg::cnt_w'(fb - 1));

	// Pins show bit n of the frame in the cycle after count n
	always_ff @(posedge ac97_bitclk or negedge ac97_reset_b) begin
		if (!ac97_reset_b) begin
			state <= audio_pkg::link_reset;
			cnt <= '0;
			ac97_sync <= 1'b0;
			ac97_sdata_out <= 1'b0;
		end else begin
			case (state)
				audio_pkg::link_reset: state <= audio_pkg::link_run; // Count held at 0
				audio_pkg::link_run: begin
					cnt <= cnt + 1'b1; // Wraps at frame end
					ac97_sync <= (cnt < audio_pkg::cnt_w'(audio_pkg::tag_bits));
					ac97_sdata_out <= (cnt == '0) ? frame[fb-1] : shreg[fb-2];
				end
				default: state <= audio_pkg::link_reset;
			endcase
		end
	end

	// Frame latched at count 0, then shifted MSB first
	always_ff @(posedge ac97_bitclk) begin
		if (state == audio_pkg::link_run) begin
			if (cnt == '0)
				shreg <= frame[fb-2:0];
			else
				shreg <= {shreg[fb-3:0], 1'b0};
		end
	end

endmodule

// ==== rtl/audio_top.sv ====
module audio_top (
	input  logic                          ac97_bitclk,
	input  logic                          ac97_reset_b,
	input  logic                          psel,
	input  logic                          penable,
	input  logic                          pwrite,
	input  logic [audio_pkg::addr_w-1:0]  paddr,
	input  logic [31:0]                   pwdata,
	output logic [31:0]                   prdata,
	output logic                          pready,
	output logic                          pslverr,
	output logic                          ac97_sync,
	output logic                          ac97_sdata_out
);

	logic push;
	logic [audio_pkg::sample_w-1:0] push_data;
	logic pop;
	logic [audio_pkg::sample_w-1:0] pop_data;
	logic empty;
	logic full;
	logic [audio_pkg::fifo_level_w-1:0] level;
	logic play;
	logic conf_en;
	logic [audio_pkg::half_w-1:0] master_vol;
	logic [audio_pkg::half_w-1:0] pcm_vol;
	logic [audio_pkg::half_w-1:0] underrun_count;

	ac97_slot_if u_slot ();

	audio_apb_regs u_regs (
		.ac97_bitclk    (ac97_bitclk),
		.ac97_reset_b   (ac97_reset_b),
		.psel           (psel),
		.penable        (penable),
		.pwrite         (pwrite),
		.paddr          (paddr),
		.pwdata         (pwdata),
		.full           (full),
		.level          (level),
		.underrun_count (underrun_count),
		.prdata         (prdata),
		.pready         (pready),
		.pslverr        (pslverr),
		.push           (push),
		.push_data      (push_data),
		.play           (play),
		.conf_en        (conf_en),
		.master_vol     (master_vol),
		.pcm_vol        (pcm_vol)
	);

	sample_fifo u_fifo (
		.ac97_bitclk  (ac97_bitclk),
		.ac97_reset_b (ac97_reset_b),
		.push         (push),
		.push_data    (push_data),
		.pop          (pop),
		.pop_data     (pop_data),
		.empty        (empty),
		.full         (full),
		.level        (level)
	);

	pcm_slot_packer u_packer (
		.ac97_bitclk    (ac97_bitclk),
		.ac97_reset_b   (ac97_reset_b),
		.play           (play),
		.pop_data       (pop_data),
		.empty          (empty),
		.pop            (pop),
		.underrun_count (underrun_count),
		.slot           (u_slot)
	);

	ac97_conf u_conf (
		.ac97_bitclk  (ac97_bitclk),
		.ac97_reset_b (ac97_reset_b),
		.conf_en      (conf_en),
		.master_vol   (master_vol),
		.pcm_vol      (pcm_vol),
		.slot         (u_slot)
	);

	ac_link_tx u_link (
		.ac97_bitclk    (ac97_bitclk),
		.ac97_reset_b   (ac97_reset_b),
		.ac97_sync      (ac97_sync),
		.ac97_sdata_out (ac97_sdata_out),
		.slot           (u_slot)
	);

endmodule

// ==== bench/audio_assert.sv ====
module audio_assert (
	input logic ac97_bitclk,
	input logic ac97_reset_b,
	input logic ac97_sync,
	input logic psel,
	input logic penable,
	input logic pready
);

	// Tag slot length
	sync_width: assert property (@(posedge ac97_bitclk) disable iff (!ac97_reset_b)
		$rose(ac97_sync) |-> ##16 $fell(ac97_sync))
		else $error("ac97_sync high period is not 16 cycles");

	sync_period: assert property (@(posedge ac97_bitclk) disable iff (!ac97_reset_b)
		$rose(ac97_sync) |-> ##256 $rose(ac97_sync))
		else $error("ac97_sync period is not 256 cycles");

	// No wait states
	apb_ready: assert property (@(posedge ac97_bitclk) disable iff (!ac97_reset_b)
		(psel && penable) |-> pready)
		else $error("pready low in an APB access cycle");

endmodule

bind audio_top audio_assert u_assert (
	.ac97_bitclk  (ac97_bitclk),
	.ac97_reset_b (ac97_reset_b),
	.ac97_sync    (ac97_sync),
	.psel         (psel),
	.penable      (penable),
	.pready       (pready)
);

// ==== bench/audio_tb.sv ====
module audio_tb;

	localparam int clk_period = 100;
	localparam int timeout_frames = 60;
	localparam logic [255:0] sync_pattern = {{16{1'b1}}, {240{1'b0}}};

	logic ac97_bitclk;
	logic ac97_reset_b;
	logic psel;
	logic penable;
	logic pwrite;
	logic [3:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic ac97_sync;
	logic ac97_sdata_out;

	int errors = 0;
	int checks = 0;
	int frames = 0;
	int bit_pos = 0; // Bit index within the frame being captured
	logic sync_d = 1'b0;
	logic in_frame = 1'b0;
	logic expect_rise = 1'b0;
	logic [255:0] cap;
	logic [255:0] sync_cap;
	logic [255:0] exp_cur = '0; // First frame after reset is all zero
	logic [255:0] exp_next = '0;
	logic [255:0] chk_got;
	logic [255:0] chk_sync;
	logic [255:0] chk_exp;
	event frame_done;

	// Model of the host side view
	logic [31:0] model_q[$];
	logic m_play = 1'b0;
	logic m_conf = 1'b0;
	logic [15:0] m_mvol = '0;
	logic [15:0] m_pvol = '0;
	logic [15:0] m_under = '0;
	logic conf_next_pcm = 1'b0;
	logic [31:0] vol;

	audio_top u_dut (.*);

	initial begin
		ac97_bitclk = 1'b0;
		forever #(clk_period / 2) ac97_bitclk = ~ac97_bitclk;
	end

	initial begin
		#(timeout_frames * audio_pkg::frame_bits * clk_period);
		$display("watchdog timeout, run did not end within %0d frames", timeout_frames);
		$display("frames %0d, checks %0d, errors %0d", frames, checks, errors);
		$display("RESULT: FAIL");
		$finish;
	end

	// Expected frame from tag, slots 1 to 4 and zero padding
	function automatic logic [255:0] ref_frame(input logic pcm_on, input logic [31:0] sample,
		input logic conf_on, input logic conf_pcm, input logic [15:0] mvol,
		input logic [15:0] pvol);
		logic [15:0] tag;
		logic [19:0] s1;
		logic [19:0] s2;
		logic [19:0] s3;
		logic [19:0] s4;
		tag = {conf_on | pcm_on, conf_on, conf_on, pcm_on, pcm_on, 11'b0};
		s1 = '0;
		s2 = '0;
		s3 = '0;
		s4 = '0;
		if (conf_on) begin
			s1 = {1'b0, conf_pcm ? 7'h18 : 7'h02, 12'h000}; // PCM or master volume
			s2 = {conf_pcm ? pvol : mvol, 4'h0};
		end
		if (pcm_on) begin
			s3 = {sample[31:16], 4'h0};
			s4 = {sample[15:0], 4'h0};
		end
		return {tag, s1, s2, s3, s4, 160'b0};
	endfunction

	// Model step at the strobe that precedes the next frame
	task automatic predict_next();
		logic pcm_on;
		logic conf_pcm;
		logic [31:0] sample;
		pcm_on = m_play && (model_q.size() != 0);
		sample = 32'h0;
		if (pcm_on)
			sample = model_q.pop_front();
		else if (m_play && m_under != 16'hffff)
			m_under = m_under + 16'd1; // Saturating underrun count
		conf_pcm = conf_next_pcm;
		conf_next_pcm = m_conf && !conf_next_pcm;
		exp_next = ref_frame(pcm_on, sample, m_conf, conf_pcm, m_mvol, m_pvol);
	endtask

	// Frame deserializer sampling mid-cycle
	always @(negedge ac97_bitclk) begin
		if (ac97_reset_b) begin
			if (ac97_sync && !sync_d) begin
				if (in_frame) begin
					errors++;
					$display("ac97_sync rose again after only %0d bits", bit_pos + 1);
				end
				in_frame = 1'b1;
				expect_rise = 1'b0;
				bit_pos = 0;
			end else if (in_frame) begin
				bit_pos++;
			end else if (expect_rise) begin
				errors++;
				$display("ac97_sync did not rise again after 256 bits");
				expect_rise = 1'b0;
			end
			if (in_frame) begin
				cap = {cap[254:0], ac97_sdata_out};
				sync_cap = {sync_cap[254:0], ac97_sync};
				if (bit_pos == 254)
					predict_next();
				if (bit_pos == 255) begin
					chk_got = cap;
					chk_sync = sync_cap;
					chk_exp = exp_cur;
					exp_cur = exp_next;
					in_frame = 1'b0;
					expect_rise = 1'b1;
					frames++;
					->frame_done;
				end
			end
		end
		sync_d = ac97_sync;
	end

	initial begin
		forever begin
			@(frame_done);
			checks += 2;
			if (chk_sync !== sync_pattern) begin
				errors++;
				$display("error: ac97_sync frame %0d got %h exp %h", frames, chk_sync,
					sync_pattern);
			end
			if (chk_got !== chk_exp) begin
				errors++;
				$display("error: ac97_sdata_out frame %0d got %h exp %h", frames, chk_got,
					chk_exp);
			end
		end
	end

	task automatic wait_frames(input int n);
		repeat (n) @(frame_done);
	endtask

	task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(negedge ac97_bitclk);
		while (bit_pos >= 236)
			@(negedge ac97_bitclk); // Keep access edges clear of the frame strobe
		psel = 1'b1;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge ac97_bitclk);
		penable = 1'b1;
		#(clk_period / 4); // Access phase response, settled before its rising edge
		rdata = prdata;
		err = pslverr;
		checks++;
		if (pready !== 1'b1) begin
			errors++;
			$display("error: pready got %h exp 1 at paddr %h", pready, addr);
		end
		@(negedge ac97_bitclk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_resp(input logic [3:0] addr, input logic [31:0] rdata,
		input logic err, input logic [31:0] exp_rdata, input logic exp_err,
		input logic is_read);
		checks++;
		if (err !== exp_err) begin
			errors++;
			$display("error: pslverr got %h exp %h at paddr %h", err, exp_err, addr);
		end
		if (is_read && !exp_err && rdata !== exp_rdata) begin
			errors++;
			$display("error: prdata got %h exp %h at paddr %h", rdata, exp_rdata, addr);
		end
	endtask

	task automatic access_check(input logic wr, input logic [3:0] addr,
		input logic [31:0] wdata, input logic [31:0] exp_rdata, input logic exp_err);
		logic [31:0] rdata;
		logic err;
		apb_xfer(wr, addr, wdata, rdata, err);
		check_resp(addr, rdata, err, exp_rdata, exp_err, !wr);
	endtask

	task automatic push_sample(input logic [31:0] data);
		logic [31:0] rdata;
		logic err;
		logic exp_err;
		apb_xfer(1'b1, audio_pkg::addr_sample, data, rdata, err);
		exp_err = (model_q.size() == audio_pkg::fifo_depth); // Full FIFO drops the word
		check_resp(audio_pkg::addr_sample, rdata, err, 32'h0, exp_err, 1'b0);
		if (!exp_err)
			model_q.push_back(data);
	endtask

	task automatic status_check();
		logic [31:0] rdata;
		logic err;
		apb_xfer(1'b0, audio_pkg::addr_status, 32'h0, rdata, err);
		check_resp(audio_pkg::addr_status, rdata, err,
			{8'h00, m_under, 3'b000, 5'(model_q.size())}, 1'b0, 1'b1);
	endtask

	initial begin
		void'($urandom(32'h6acf));
		ac97_reset_b = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 4'h0;
		pwdata = 32'h0;
		repeat (8) begin
			@(negedge ac97_bitclk);
			checks++;
			if (ac97_sync !== 1'b0 || ac97_sdata_out !== 1'b0) begin
				errors++;
				$display("error: ac97_sync %h ac97_sdata_out %h exp 0 in reset", ac97_sync,
					ac97_sdata_out);
			end
		end
		ac97_reset_b = 1'b1;

		status_check();
		wait_frames(2);

		// Register readback and slave errors
		vol = $urandom();
		access_check(1'b1, audio_pkg::addr_volume, vol, 32'h0, 1'b0);
		m_mvol = vol[15:0];
		m_pvol = vol[31:16];
		access_check(1'b0, audio_pkg::addr_volume, 32'h0, vol, 1'b0);
		access_check(1'b0, audio_pkg::addr_ctrl, 32'h0, 32'h0, 1'b0);
		access_check(1'b0, 4'h2, 32'h0, 32'h0, 1'b1); // Unmapped
		access_check(1'b1, 4'h6, $urandom(), 32'h0, 1'b1);
		access_check(1'b0, audio_pkg::addr_sample, 32'h0, 32'h0, 1'b1);

		// Fill while stopped so the last write overflows
		repeat (audio_pkg::fifo_depth + 1)
			push_sample($urandom());
		status_check();

		// Playback then drain into underrun
		access_check(1'b1, audio_pkg::addr_ctrl, 32'h1, 32'h0, 1'b0);
		m_play = 1'b1;
		access_check(1'b0, audio_pkg::addr_ctrl, 32'h0, 32'h1, 1'b0);
		wait_frames(4);
		repeat (4)
			push_sample($urandom());
		status_check();
		wait_frames(20);
		status_check();
		access_check(1'b1, audio_pkg::addr_ctrl, 32'h0, 32'h0, 1'b0);
		m_play = 1'b0;

		// Codec configuration writes
		access_check(1'b1, audio_pkg::addr_ctrl, 32'h2, 32'h0, 1'b0);
		m_conf = 1'b1;
		access_check(1'b0, audio_pkg::addr_ctrl, 32'h0, 32'h2, 1'b0);
		wait_frames(3);
		vol = $urandom();
		access_check(1'b1, audio_pkg::addr_volume, vol, 32'h0, 1'b0);
		m_mvol = vol[15:0];
		m_pvol = vol[31:16];
		wait_frames(3);
		access_check(1'b1, audio_pkg::addr_ctrl, 32'h0, 32'h0, 1'b0);
		m_conf = 1'b0;
		wait_frames(2);
		status_check();

		$display("frames %0d, checks %0d, errors %0d", frames, checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== files.f ====
rtl/audio_pkg.sv
rtl/ac97_slot_if.sv
rtl/audio_apb_regs.sv
rtl/sample_fifo.sv
rtl/pcm_slot_packer.sv
rtl/ac97_conf.sv
rtl/ac_link_tx.sv
rtl/audio_top.sv
bench/audio_assert.sv
bench/audio_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= audio_tb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
